// File: design/img_pkg.sv
`default_nettype none

package img_pkg;

	// frame geometry, QQVGA halved
	localparam int img_cols = 80;
	localparam int img_rows = 60;
	localparam int img_pxls = img_cols * img_rows; // 4800 words in the frame RAM

	localparam int addr_w = 13; // 2^13 covers 4800
	localparam int col_w  = 7;  // 0..79
	localparam int row_w  = 6;  // 0..59
	localparam int pxl_w  = 12; // rgb444
	localparam int hist_w = 6;  // at most 48 window rows per column

	// central window used by the histogram, 64 x 48 pixels
	localparam int win_col_lo = 8;
	localparam int win_col_hi = 71;
	localparam int win_row_lo = 6;
	localparam int win_row_hi = 53;

	// a strong red has little green and little blue
	localparam logic [3:0] green_limit = 4'd9;
	localparam logic [3:0] blue_limit  = 4'd9;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [2:0] filter_t; // red, green, blue enable, red is the msb

	localparam filter_t filt_none = 3'b000; // pass through
	localparam filter_t filt_red  = 3'b100; // red qualifier instead of msb test

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb444_t;

	// one memory word, seen raw or as colour fields
	typedef union packed {
		logic [pxl_w-1:0] raw;
		rgb444_t          rgb;
	} pixel_u;

	// red qualification, shared by the red filter and the histogram
	function automatic logic is_red(pixel_u p);
		return p.rgb.red[3] && (p.rgb.green < green_limit) && (p.rgb.blue < blue_limit);
	endfunction

endpackage

`default_nettype wire

// File: design/mem_port_if.sv
`timescale 1ns/100ps
`default_nettype none

// one requester's port into the shared frame RAM
interface mem_port_if #(
	parameter int data_w = img_pkg::pxl_w
);
	logic              req;   // held while an access is wanted
	logic              we;    // write when granted, else read
	img_pkg::addr_t    addr;
	logic [data_w-1:0] wdata;
	logic              gnt;   // access happens when req and gnt are both high
	logic [data_w-1:0] rdata; // valid the cycle after a granted read

	modport requester (output req, we, addr, wdata, input gnt, rdata);
	modport arbiter (input req, we, addr, wdata, output gnt, rdata);
endinterface

`default_nettype wire

// File: design/frame_ram.sv
`timescale 1ns/100ps
`default_nettype none

module frame_ram (
	input  wire             clk,
	input  wire             we,
	input  wire img_pkg::addr_t  addr,
	input  wire img_pkg::pixel_u wdata,
	output img_pkg::pixel_u rdata
);

	img_pkg::pixel_u mem [img_pkg::img_pxls]; // original image, one word per pixel

	// single port, registered read
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // old contents on a write cycle
	end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  wire                  clk,
	input  wire                  rst,
	mem_port_if.arbiter          cam,
	mem_port_if.arbiter          proc,
	output logic                 ram_we,
	output img_pkg::addr_t       ram_addr,
	output img_pkg::pixel_u      ram_wdata,
	input  wire img_pkg::pixel_u ram_rdata
);

	logic last_cam; // 1 when the camera won the last grant
	logic cam_win;
	logic proc_win;

	// camera wins when alone, or on a conflict if it did not win last time
	assign cam_win  = cam.req & (~proc.req | ~last_cam);
	assign proc_win = proc.req & ~cam_win;

	assign cam.gnt  = cam_win;
	assign proc.gnt = proc_win;

	// remember the winner for the next conflict
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_cam <= 1'b0; // camera first on the first conflict
		end else if (cam_win) begin
			last_cam <= 1'b1;
		end else if (proc_win) begin
			last_cam <= 1'b0;
		end
	end

	// steer the winner onto the single RAM port
	always_comb begin
		if (cam_win) begin
			ram_we    = cam.we;
			ram_addr  = cam.addr;
			ram_wdata = cam.wdata;
		end else begin
			ram_we    = proc_win & proc.we; // no write when idle
			ram_addr  = proc.addr;
			ram_wdata = proc.wdata;
		end
	end

	// read data goes back to both, only the granted reader uses it
	assign cam.rdata  = ram_rdata;
	assign proc.rdata = ram_rdata;

endmodule

`default_nettype wire

// File: design/cam_writer.sv
`timescale 1ns/100ps
`default_nettype none

module cam_writer (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  cam_we,
	input  wire img_pkg::addr_t  cam_addr,
	input  wire img_pkg::pixel_u cam_pxl,
	mem_port_if.requester        port,
	output logic                 cam_overrun
);

	img_pkg::addr_t  addr_q [2]; // queued write addresses
	img_pkg::pixel_u pxl_q [2];  // queued pixels
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;           // 0, 1 or 2 entries
	logic       not_empty;
	logic       full;
	logic       push;
	logic       pop;

	assign not_empty = count != 2'd0;
	assign full      = count == 2'd2;
	assign push      = cam_we & ~full;  // a strobe into a full queue is lost
	assign pop       = not_empty & port.gnt;

	// head of the queue drives the port, writes only
	assign port.req   = not_empty;
	assign port.we    = not_empty;
	assign port.addr  = addr_q[rd_ptr];
	assign port.wdata = pxl_q[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			addr_q[wr_ptr] <= cam_addr;
			pxl_q[wr_ptr]  <= cam_pxl;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr      <= 1'b0;
			rd_ptr      <= 1'b0;
			count       <= 2'd0;
			cam_overrun <= 1'b0;
		end else begin
			if (push) wr_ptr <= ~wr_ptr;
			if (pop) rd_ptr <= ~rd_ptr;
			if (push & ~pop) begin
				count <= count + 2'd1;
			end else if (pop & ~push) begin
				count <= count - 2'd1;
			end
			if (cam_we & full) cam_overrun <= 1'b1; // sticky until reset
		end
	end

endmodule

`default_nettype wire

// File: design/red_histogram.sv
`timescale 1ns/100ps
`default_nettype none

module red_histogram (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         pxl_valid,
	input  wire [img_pkg::col_w-1:0]    col,
	input  wire [img_pkg::row_w-1:0]    row,
	input  wire img_pkg::pixel_u        pxl,
	input  wire                         frame_last,
	output logic [img_pkg::hist_w-1:0]  hist_val,
	output logic                        peak_valid,
	output logic [img_pkg::col_w-1:0]   peak_col,
	output logic [img_pkg::hist_w-1:0]  peak_count
);

	logic [img_pkg::hist_w-1:0] hist [img_pkg::img_cols]; // red count per column
	logic [img_pkg::hist_w-1:0] run_cnt;  // running maximum this frame
	logic [img_pkg::col_w-1:0]  run_col;  // column that first reached it
	logic [img_pkg::hist_w-1:0] next_cnt;
	logic in_win;
	logic count_en;
	logic new_peak;
	logic frame_end;

	// only the central 64 x 48 window is counted
	assign in_win = (col >= img_pkg::col_w'(img_pkg::win_col_lo)) &&
	                (col <= img_pkg::col_w'(img_pkg::win_col_hi)) &&
	                (row >= img_pkg::row_w'(img_pkg::win_row_lo)) &&
	                (row <= img_pkg::row_w'(img_pkg::win_row_hi));

	assign count_en  = pxl_valid & in_win & img_pkg::is_red(pxl);
	assign next_cnt  = hist[col] + 1'b1;
	assign new_peak  = count_en & (next_cnt > run_cnt); // strictly greater, first column wins ties
	assign frame_end = pxl_valid & frame_last;

	assign hist_val = count_en ? next_cnt : '0; // count including this pixel

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < img_pkg::img_cols; i++) begin
				hist[i] <= '0;
			end
			run_cnt    <= '0;
			run_col    <= '0;
			peak_valid <= 1'b0;
			peak_col   <= '0;
			peak_count <= '0;
		end else begin
			peak_valid <= frame_end;
			if (frame_end) begin
				// publish, the last pixel may still raise the peak
				peak_col   <= new_peak ? col : run_col;
				peak_count <= new_peak ? next_cnt : run_cnt;
				for (int i = 0; i < img_pkg::img_cols; i++) begin
					hist[i] <= '0; // fresh histogram for the next frame
				end
				run_cnt <= '0;
				run_col <= '0;
			end else begin
				if (count_en) hist[col] <= next_cnt;
				if (new_peak) begin
					run_cnt <= next_cnt;
					run_col <= col;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/image_proc.sv
`timescale 1ns/100ps
`default_nettype none

module image_proc (
	input  wire                         clk,
	input  wire                         rst,
	input  wire img_pkg::filter_t       rgbfilter,
	mem_port_if.requester               port,
	output logic                        proc_we,
	output img_pkg::addr_t              proc_addr,
	output img_pkg::pixel_u             proc_pxl,
	output logic [img_pkg::hist_w-1:0]  hist_val,
	output logic                        frame_start,
	output logic                        peak_valid,
	output logic [img_pkg::col_w-1:0]   peak_col,
	output logic [img_pkg::hist_w-1:0]  peak_count
);

	logic                      req_q;     // low in reset, then always requesting
	logic                      grant;
	img_pkg::addr_t            scan_addr;
	logic [img_pkg::col_w-1:0] scan_col;
	logic [img_pkg::row_w-1:0] scan_row;
	logic                      scan_last;
	logic                      rd_valid;  // granted read last cycle
	logic [img_pkg::col_w-1:0] rd_col;
	logic [img_pkg::row_w-1:0] rd_row;
	logic                      rd_last;
	img_pkg::pixel_u           rd_pxl;
	logic                      pass;

	// read-only requester
	assign port.req   = req_q;
	assign port.we    = 1'b0;
	assign port.addr  = scan_addr;
	assign port.wdata = '0;

	assign grant       = req_q & port.gnt;
	assign scan_last   = scan_addr == img_pkg::addr_t'(img_pkg::img_pxls - 1);
	assign frame_start = grant & scan_last;

	// scan counters move only on grant, a lost arbitration just retries
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req_q     <= 1'b0;
			scan_addr <= '0;
			scan_col  <= '0;
			scan_row  <= '0;
		end else begin
			req_q <= 1'b1;
			if (grant) begin
				if (scan_last) begin
					scan_addr <= '0; // wrap to the next frame
					scan_col  <= '0;
					scan_row  <= '0;
				end else begin
					scan_addr <= scan_addr + 1'b1;
					if (scan_col == img_pkg::col_w'(img_pkg::img_cols - 1)) begin
						scan_col <= '0; // end of line
						scan_row <= scan_row + 1'b1;
					end else begin
						scan_col <= scan_col + 1'b1;
					end
				end
			end
		end
	end

	// RAM data arrives one cycle late, delay position to match
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_valid  <= 1'b0;
			proc_addr <= '0;
			rd_col    <= '0;
			rd_row    <= '0;
			rd_last   <= 1'b0;
		end else begin
			rd_valid <= grant;
			if (grant) begin
				proc_addr <= scan_addr;
				rd_col    <= scan_col;
				rd_row    <= scan_row;
				rd_last   <= scan_last;
			end
		end
	end

	assign proc_we = rd_valid;
	assign rd_pxl  = port.rdata;

	// colour filter, failing pixels go black
	always_comb begin
		case (rgbfilter)
			img_pkg::filt_none: pass = 1'b1;
			img_pkg::filt_red:  pass = img_pkg::is_red(rd_pxl);
			default: begin
				// every enabled colour needs its msb set
				pass = (~rgbfilter[2] | rd_pxl.rgb.red[3]) &
				       (~rgbfilter[1] | rd_pxl.rgb.green[3]) &
				       (~rgbfilter[0] | rd_pxl.rgb.blue[3]);
			end
		endcase
	end

	assign proc_pxl = pass ? rd_pxl : '0;

	red_histogram red_histogram_i (
		.clk        (clk),
		.rst        (rst),
		.pxl_valid  (rd_valid),
		.col        (rd_col),
		.row        (rd_row),
		.pxl        (rd_pxl),     // unfiltered pixel
		.frame_last (rd_last),
		.hist_val   (hist_val),
		.peak_valid (peak_valid),
		.peak_col   (peak_col),
		.peak_count (peak_count)
	);

endmodule

`default_nettype wire

// File: design/img_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

module img_filter_top (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         cam_we,
	input  wire [img_pkg::addr_w-1:0]   cam_addr,
	input  wire [img_pkg::pxl_w-1:0]    cam_pxl,
	input  wire img_pkg::filter_t       rgbfilter,
	output logic                        proc_we,
	output logic [img_pkg::addr_w-1:0]  proc_addr,
	output logic [img_pkg::pxl_w-1:0]   proc_pxl,
	output logic [img_pkg::hist_w-1:0]  hist_val,
	output logic                        frame_start,
	output logic                        peak_valid,
	output logic [img_pkg::col_w-1:0]   peak_col,
	output logic [img_pkg::hist_w-1:0]  peak_count,
	output logic                        cam_overrun
);

	mem_port_if #(.data_w(img_pkg::pxl_w)) cam_port ();  // camera writer side
	mem_port_if #(.data_w(img_pkg::pxl_w)) proc_port (); // scanner side

	logic            ram_we;
	img_pkg::addr_t  ram_addr;
	img_pkg::pixel_u ram_wdata;
	img_pkg::pixel_u ram_rdata;

	cam_writer cam_writer_i (
		.clk         (clk),
		.rst         (rst),
		.cam_we      (cam_we),
		.cam_addr    (cam_addr),
		.cam_pxl     (cam_pxl),
		.port        (cam_port.requester),
		.cam_overrun (cam_overrun)
	);

	image_proc image_proc_i (
		.clk         (clk),
		.rst         (rst),
		.rgbfilter   (rgbfilter),
		.port        (proc_port.requester),
		.proc_we     (proc_we),
		.proc_addr   (proc_addr),
		.proc_pxl    (proc_pxl),
		.hist_val    (hist_val),
		.frame_start (frame_start),
		.peak_valid  (peak_valid),
		.peak_col    (peak_col),
		.peak_count  (peak_count)
	);

	mem_arbiter mem_arbiter_i (
		.clk       (clk),
		.rst       (rst),
		.cam       (cam_port.arbiter),
		.proc      (proc_port.arbiter),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	frame_ram frame_ram_i (
		.clk   (clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// File: test/img_filter_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module img_filter_assertions (
	input wire                 clk,
	input wire                 rst,
	input wire                 cam_req,
	input wire                 cam_gnt,
	input wire                 proc_req,
	input wire                 proc_gnt,
	input wire                 proc_we,
	input wire img_pkg::addr_t proc_addr,
	input wire                 peak_valid
);

	int fail_count = 0; // failed assertions so far

	// one RAM port, so at most one winner
	assert property (@(posedge clk) disable iff (rst) !(cam_gnt && proc_gnt))
		else begin $error("both ports granted in one cycle"); fail_count++; end

	// no conflict means no waiting
	assert property (@(posedge clk) disable iff (rst) (proc_req && !cam_req) |-> proc_gnt)
		else begin $error("lone scanner request not granted"); fail_count++; end

	// peak report one cycle after the last pixel of the frame
	assert property (@(posedge clk) disable iff (rst)
		(proc_we && proc_addr == img_pkg::addr_t'(img_pkg::img_pxls - 1)) |=> peak_valid)
		else begin $error("peak_valid missing after last pixel"); fail_count++; end

	assert property (@(posedge clk) rst |-> !proc_we)
		else begin $error("proc_we high during reset"); fail_count++; end

endmodule

`default_nettype wire

// File: test/tb_img_filter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_img_filter;

	logic clk;
	logic rst;
	logic cam_we;
	img_pkg::addr_t cam_addr;
	logic [img_pkg::pxl_w-1:0] cam_pxl;
	img_pkg::filter_t rgbfilter;
	logic proc_we;
	img_pkg::addr_t proc_addr;
	logic [img_pkg::pxl_w-1:0] proc_pxl;
	logic [img_pkg::hist_w-1:0] hist_val;
	logic frame_start;
	logic peak_valid;
	logic [img_pkg::col_w-1:0] peak_col;
	logic [img_pkg::hist_w-1:0] peak_count;
	logic cam_overrun;

	logic [11:0] model [img_pkg::img_pxls]; // what the frame RAM should hold
	int mcount [img_pkg::img_cols];         // model red count per column
	int mpeak_cnt = 0;
	int mpeak_col = 0;
	int exp_peak_cnt = 0;                   // peak of the finished frame
	int exp_peak_col = 0;
	logic [31:0] lfsr_state;
	int errors = 0;
	int checks = 0;
	int frames_seen = 0;
	int peaks_seen = 0;
	int pw_count = 0;   // proc_we since the last frame_start
	int exp_addr = 0;
	logic armed = 0;    // frame loaded, sync on next frame_start
	logic checking = 0;
	logic hist_live = 0; // model histogram aligned with the DUT
	logic peak_pending = 0;
	int a;
	int col;
	int row;
	int exp_hist;
	logic [11:0] pix;

	img_filter_top img_filter_top_i (.*);

	bind img_filter_top img_filter_assertions img_filter_assertions_i (
		.clk        (clk),
		.rst        (rst),
		.cam_req    (cam_port.req),
		.cam_gnt    (cam_port.gnt),
		.proc_req   (proc_port.req),
		.proc_gnt   (proc_port.gnt),
		.proc_we    (proc_we),
		.proc_addr  (proc_addr),
		.peak_valid (peak_valid)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [11:0] rand_bits(input int n);
		logic [11:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			v = {v[10:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic red_ref(input logic [11:0] p);
		return p[11] && (p[7:4] < img_pkg::green_limit) && (p[3:0] < img_pkg::blue_limit);
	endfunction

	// expected processed pixel
	function automatic logic [11:0] ref_filter(input logic [11:0] p, input logic [2:0] code);
		logic ok;
		if (code == 3'b000) ok = 1'b1;
		else if (code == 3'b100) ok = red_ref(p);
		else ok = (!code[2] || p[11]) && (!code[1] || p[7]) && (!code[0] || p[3]);
		return ok ? p : 12'h000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_idle(input string name);
		check_value({name, " proc_we"}, 0, proc_we);
		check_value({name, " frame_start"}, 0, frame_start);
		check_value({name, " peak_valid"}, 0, peak_valid);
		check_value({name, " cam_overrun"}, 0, cam_overrun);
	endtask

	task automatic wait_frames(input int n);
		int target;
		int waited;
		target = frames_seen + n;
		waited = 0;
		while (frames_seen < target && waited < n * 12000) begin
			@(posedge clk);
			waited++;
		end
		if (frames_seen < target) begin
			$display("timeout: frame_start did not come within %0d cycles", waited);
			$display("Testbench failed");
			$finish;
		end
	endtask

	// sample at the falling edge, all outputs settled
	always @(negedge clk) begin
		if (checking && peak_valid && peak_pending) begin
			check_value("peak_col", exp_peak_col, peak_col);
			check_value("peak_count", exp_peak_cnt, peak_count);
			peaks_seen++;
			peak_pending = 0;
		end
		if (checking && proc_we) begin
			a = proc_addr;
			pix = model[a];
			check_value("proc_addr order", exp_addr, proc_addr);
			check_value("proc_pxl", ref_filter(pix, rgbfilter), proc_pxl);
			exp_addr = (a == img_pkg::img_pxls - 1) ? 0 : a + 1; // wraps after 4799
			col = a % img_pkg::img_cols;
			row = a / img_pkg::img_cols;
			if (hist_live) begin
				exp_hist = 0;
				if (col >= img_pkg::win_col_lo && col <= img_pkg::win_col_hi &&
				    row >= img_pkg::win_row_lo && row <= img_pkg::win_row_hi && red_ref(pix)) begin
					mcount[col]++;
					exp_hist = mcount[col];
					if (mcount[col] > mpeak_cnt) begin // first column to a new max wins
						mpeak_cnt = mcount[col];
						mpeak_col = col;
					end
				end
				check_value("hist_val", exp_hist, hist_val);
			end
			if (a == img_pkg::img_pxls - 1) begin
				if (hist_live) begin
					exp_peak_cnt = mpeak_cnt;
					exp_peak_col = mpeak_col;
					peak_pending = 1;
				end
				foreach (mcount[i]) mcount[i] = 0; // both sides restart here
				mpeak_cnt = 0;
				mpeak_col = 0;
				hist_live = 1;
			end
			pw_count++;
		end
		if (frame_start) begin
			if (checking) begin
				check_value("proc_we per frame", img_pkg::img_pxls, pw_count);
				frames_seen++;
			end else if (armed) begin
				checking = 1; // 4799 is the next pixel out
				exp_addr = img_pkg::img_pxls - 1;
				frames_seen++;
			end
			pw_count = 0;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cam_we = 1'b0;
		cam_addr = '0;
		cam_pxl = '0;
		rgbfilter = '0;
		lfsr_state = 32'h18e1_f5da;
		foreach (mcount[i]) mcount[i] = 0;

		// random frame, column 37 strongly red in every row
		for (int i = 0; i < img_pkg::img_pxls; i++) begin
			if (i % img_pkg::img_cols == 37) begin
				pix = rand_bits(9);
				model[i] = {1'b1, pix[8:6], 1'b0, pix[5:3], 1'b0, pix[2:0]};
			end else begin
				model[i] = rand_bits(12);
			end
		end

		repeat (10) begin
			@(posedge clk);
			#1;
			check_idle("reset");
		end
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_idle("after reset");

		// load through the camera port, one strobe every other cycle
		for (int i = 0; i < img_pkg::img_pxls; i++) begin
			@(posedge clk);
			#1;
			cam_we = 1'b1;
			cam_addr = img_pkg::addr_t'(i);
			cam_pxl = model[i];
			@(posedge clk);
			#1;
			cam_we = 1'b0;
		end
		check_value("overrun after load", 0, cam_overrun);
		repeat (4) @(posedge clk); // queue drained
		armed = 1'b1;
		wait_frames(1);

		// each code over at least one whole frame
		for (int f = 0; f < 8; f++) begin
			@(posedge clk);
			#1;
			rgbfilter = img_pkg::filter_t'(f);
			wait_frames(2);
		end

		// same data again, so lost strobes leave the frame unchanged
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			cam_we = 1'b1;
			cam_addr = img_pkg::addr_t'(200 + i);
			cam_pxl = model[200 + i];
		end
		@(posedge clk);
		#1;
		cam_we = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		check_value("overrun set", 1, cam_overrun);
		wait_frames(2);
		check_value("overrun sticky", 1, cam_overrun);

		check_value("peak reports seen", 1, peaks_seen > 0);
		check_value("assertion failures", 0, img_filter_top_i.img_filter_assertions_i.fail_count);
		$display("summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
design/img_pkg.sv
design/mem_port_if.sv
design/frame_ram.sv
design/mem_arbiter.sv
design/cam_writer.sv
design/red_histogram.sv
design/image_proc.sv
design/img_filter_top.sv
test/img_filter_assertions.sv
test/tb_img_filter.sv

// File: Bender.yml
package:
  name: img_filter

sources:
  - design/img_pkg.sv
  - design/mem_port_if.sv
  - design/frame_ram.sv
  - design/mem_arbiter.sv
  - design/cam_writer.sv
  - design/red_histogram.sv
  - design/image_proc.sv
  - design/img_filter_top.sv
  - target: test
    files:
      - test/img_filter_assertions.sv
      - test/tb_img_filter.sv
